/* Makefile */
SIM        := verilator
TOP        := host_bridge_tb
FILELIST   := tb.f
FLAGS      := --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS := --lint-only --timing -Wall --timescale 1ns/10ps
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Result: FAILED
PASS_MSG   := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/host_bridge_props.sv */
`timescale 1ns/10ps

module host_bridge_props (
	input logic            okClk,
	input logic            rst,
	input logic            valid,
	input logic            ready,
	input host_pkg::word_t data,
	input logic            wr,
	input logic            full,
	input logic            reset_low      // flags that must clear on reset
);

	// an unaccepted valid holds its word
	valid_hold: assert property (@(posedge okClk) disable iff (rst)
		valid && !ready |=> valid && $stable(data))
		else $error("valid dropped or data changed before the transfer");

	no_full_write: assert property (@(posedge okClk) disable iff (rst) !(wr && full))
		else $error("write into a full FIFO");

	reset_clear: assert property (@(posedge okClk) rst |=> !reset_low)
		else $error("flag or valid still high in the cycle after reset");

endmodule

//------------------------------
// attach to the stages
//------------------------------
bind pipe_in_stage host_bridge_props in_props (.okClk(okClk), .rst(rst),
	.valid(in_valid), .ready(in_ready), .data(in_data), .wr(pi_write),
	.full(fifo_count == host_pkg::fifo_count_t'(host_pkg::FIFO_DEPTH)),
	.reset_low(pipe_in_ready || in_valid));

bind op_dispatch host_bridge_props lb_props (.okClk(okClk), .rst(rst),
	.valid(lb_valid), .ready(lb_ready), .data(lb_data), .wr(1'b0), .full(1'b0),
	.reset_low(lb_valid));

bind op_dispatch host_bridge_props eg_props (.okClk(okClk), .rst(rst),
	.valid(eg_valid), .ready(eg_ready), .data(eg_data), .wr(1'b0), .full(1'b0),
	.reset_low(eg_valid));

// loopback writes are gated by lb_ready inside the stage
bind pipe_out_stage host_bridge_props out_props (.okClk(okClk), .rst(rst),
	.valid(po_valid), .ready(po_read), .data(po_data), .wr(1'b0),
	.full(1'b0), .reset_low(pipe_out_ready || po_valid));

/* bench/host_bridge_tb.sv */
`timescale 1ns/10ps

module host_bridge_tb;
	import host_pkg::*;

	localparam logic [31:0] SEED = 32'he4da_83c6;
	localparam int NUM_TESTS = 7;
	localparam int HOLD_CYCLES = 300;         // eng_ready low stretch
	localparam int SETTLE = 10;
	localparam logic [1:0] RDY_HIGH = 2'd0;
	localparam logic [1:0] RDY_RANDOM = 2'd1;
	localparam logic [1:0] RDY_HOLD = 2'd2;
	localparam logic [1:0] BAD_NONE = 2'd0;
	localparam logic [1:0] BAD_TYPE = 2'd1;   // reserved type in front
	localparam logic [1:0] BAD_ZERO = 2'd2;   // zero count in front

	typedef struct packed {
		logic        op_en;
		op_type_t    op;
		logic [15:0] count;                   // payload words, or loopback words
		logic [1:0]  bad;
		logic [1:0]  rdy;                     // eng_ready pattern
		logic        read_po;
	} test_row_t;

	localparam test_row_t TESTS [NUM_TESTS] = '{
		'{1'b0, OP_NONE,    16'd48,  BAD_NONE, RDY_HIGH,   1'b1},
		'{1'b1, OP_CONV3X3, 16'd20,  BAD_NONE, RDY_HIGH,   1'b1},
		'{1'b1, OP_CONV1X1, 16'd1,   BAD_TYPE, RDY_HIGH,   1'b1},
		'{1'b1, OP_MAXPOOL, 16'd9,   BAD_ZERO, RDY_RANDOM, 1'b1},
		'{1'b1, OP_AVEPOOL, 16'd40,  BAD_NONE, RDY_RANDOM, 1'b1},
		'{1'b1, OP_CONV3X3, 16'd120, BAD_NONE, RDY_HOLD,   1'b1},
		'{1'b0, OP_NONE,    16'd16,  BAD_NONE, RDY_HIGH,   1'b0}    // block flag
	};

	logic        okClk;
	logic        rst;
	logic        op_en;
	logic        pi_write;
	word_t       pi_data;
	logic        pipe_in_ready;
	logic        po_valid;
	word_t       po_data;
	logic        po_read;
	logic        pipe_out_ready;
	logic        eng_valid;
	word_t       eng_data;
	op_type_t    eng_op_type;
	logic        eng_last;
	logic        eng_ready = 1'b0;
	logic [1:0]  rdy_mode = RDY_HIGH;
	logic        hold_low = 1'b0;
	logic [31:0] rdy_seed = SEED;
	logic [31:0] data_seed = SEED;

	word_t    host_words[$];
	word_t    lb_exp[$];
	word_t    eng_exp_data[$];
	op_type_t eng_exp_type[$];
	logic     eng_exp_last[$];
	int       written;
	int       tests_run = 0;
	int       mon_checks = 0;                 // scoreboard process
	int       mon_errors = 0;
	int       run_checks = 0;                 // main process
	int       run_errors = 0;

	host_bridge dut0 (.*);

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int total_words();
		int n;
		n = 0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			n += int'(TESTS[i].count) + (TESTS[i].op_en ? 1 : 0);
			n += (TESTS[i].bad != BAD_NONE) ? 1 : 0;
		end
		return n;
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp,
			inout int n_checks, inout int n_errors);
		n_checks++;
		assert (got === exp) else begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			n_errors++;
		end
	endtask

	//------------------------------
	// stimulus
	//------------------------------
	task automatic load_row(input test_row_t row);
		word_t w;
		host_words.delete();
		if (row.bad == BAD_TYPE) begin
			host_words.push_back({3'd5, 13'd0, 16'd3});
		end else if (row.bad == BAD_ZERO) begin
			host_words.push_back({OP_CONV3X3, 13'd0, 16'd0});
		end
		if (row.op_en) begin
			host_words.push_back({row.op, 13'd0, row.count});
		end
		for (int k = 0; k < int'(row.count); k++) begin
			data_seed = xorshift(data_seed);
			w = data_seed;
			host_words.push_back(w);
			if (row.op_en) begin
				eng_exp_data.push_back(w);
				eng_exp_type.push_back(row.op);
				eng_exp_last.push_back(k == int'(row.count) - 1);   // last on the Nth only
			end else begin
				lb_exp.push_back(w);
			end
		end
	endtask

	// host side, one block per pipe_in_ready
	task automatic send_words(input int first, input int n);
		int sent;
		sent = 0;
		while (sent < n) begin
			@(posedge okClk);
			if (pipe_in_ready) begin
				for (int i = 0; i < BLOCK_SIZE && sent < n; i++) begin
					pi_write <= 1'b1;
					pi_data <= host_words[first + sent];
					sent++;
					written++;
					@(posedge okClk);
				end
				pi_write <= 1'b0;
				@(posedge okClk);            // throttle register catches up
			end
		end
	endtask

	task automatic hold_test(input int n);
		int upstream;
		fork
			send_words(0, n);
			begin
				repeat (HOLD_CYCLES) @(posedge okClk);
				@(negedge okClk);
				// command word, full engine FIFO and dispatch slot are past pipe-in
				upstream = written - 2 - FIFO_DEPTH;
				run_checks++;
				assert (upstream > FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE) else begin
					$display("back-pressure left only %0d words in pipe-in", upstream);
					run_errors++;
				end
				check_value("pipe_in_ready", word_t'(pipe_in_ready), '0, run_checks, run_errors);
				@(posedge okClk);
				hold_low <= 1'b0;
			end
		join
	endtask

	task automatic flag_test(input int n);
		send_words(0, n - 1);
		repeat (SETTLE) @(posedge okClk);
		@(negedge okClk);
		check_value("pipe_out_ready", word_t'(pipe_out_ready), '0, run_checks, run_errors);
		send_words(n - 1, 1);
		repeat (SETTLE) @(posedge okClk);
		@(negedge okClk);
		check_value("pipe_out_ready", word_t'(pipe_out_ready), word_t'(1),
			run_checks, run_errors);
		@(posedge okClk);
		po_read <= 1'b1;                     // drain the block
	endtask

	task automatic wait_drain();
		@(negedge okClk);
		while (eng_exp_data.size() != 0 || lb_exp.size() != 0) begin
			@(negedge okClk);
		end
		repeat (8) @(posedge okClk);          // room for stray words
	endtask

	task automatic run_test(input int idx);
		test_row_t row;
		int err_start;
		row = TESTS[idx];
		err_start = mon_errors + run_errors;
		written = 0;
		@(negedge okClk);
		load_row(row);
		@(posedge okClk);
		op_en <= row.op_en;
		po_read <= row.read_po;
		rdy_mode <= row.rdy;
		hold_low <= (row.rdy == RDY_HOLD);
		if (row.rdy == RDY_HOLD) begin
			hold_test(host_words.size());
		end else if (!row.read_po) begin
			flag_test(host_words.size());
		end else begin
			send_words(0, host_words.size());
		end
		wait_drain();
		tests_run++;
		$display("test %0d: op_en=%0b type=%0d words=%0d errors=%0d", idx, row.op_en,
			row.op, host_words.size(), mon_errors + run_errors - err_start);
	endtask

	//------------------------------
	// engine ready and scoreboards
	//------------------------------
	always @(posedge okClk) begin
		rdy_seed <= xorshift(rdy_seed);
		case (rdy_mode)
			RDY_RANDOM: eng_ready <= rdy_seed[0];
			RDY_HOLD: eng_ready <= !hold_low;
			default: eng_ready <= 1'b1;
		endcase
	end

	always @(posedge okClk) begin
		if (!rst && eng_valid && eng_ready) begin
			assert (eng_exp_data.size() != 0) else begin
				$display("engine port sent %h at %0t with no word expected", eng_data, $time);
				mon_errors++;
			end
			if (eng_exp_data.size() != 0) begin
				check_value("eng_data", eng_data, eng_exp_data.pop_front(), mon_checks, mon_errors);
				check_value("eng_op_type", word_t'(eng_op_type), word_t'(eng_exp_type.pop_front()),
					mon_checks, mon_errors);
				check_value("eng_last", word_t'(eng_last), word_t'(eng_exp_last.pop_front()),
					mon_checks, mon_errors);
			end
		end
		if (!rst && po_valid && po_read) begin
			assert (lb_exp.size() != 0) else begin
				$display("pipe-out sent %h at %0t with no word expected", po_data, $time);
				mon_errors++;
			end
			if (lb_exp.size() != 0) begin
				check_value("po_data", po_data, lb_exp.pop_front(), mon_checks, mon_errors);
			end
		end
	end

	initial begin
		int limit;
		limit = total_words() * 40 + 2000;
		repeat (limit) @(posedge okClk);
		$display("timeout, tests still running after %0d cycles", limit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst <= 1'b1;
		op_en <= 1'b0;
		pi_write <= 1'b0;
		pi_data <= '0;
		po_read <= 1'b0;
		repeat (2) @(posedge okClk);
		rst <= 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d checks, %0d errors", tests_run, mon_checks + run_checks,
			mon_errors + run_errors);
		if (mon_errors + run_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
verilog/host_pkg.sv
verilog/sync_fifo.sv
verilog/pipe_in_stage.sv
verilog/op_dispatch.sv
verilog/pipe_out_stage.sv
verilog/host_bridge.sv
bench/host_bridge_props.sv
bench/host_bridge_tb.sv

/* verilog/host_bridge.sv */
`timescale 1ns/10ps

module host_bridge (
	input  logic               okClk,
	input  logic               rst,
	input  logic               op_en,

	input  logic               pi_write,
	input  host_pkg::word_t    pi_data,
	output logic               pipe_in_ready,

	output logic               po_valid,
	output host_pkg::word_t    po_data,
	input  logic               po_read,
	output logic               pipe_out_ready,

	output logic               eng_valid,
	output host_pkg::word_t    eng_data,
	output host_pkg::op_type_t eng_op_type,
	output logic               eng_last,
	input  logic               eng_ready
);
	import host_pkg::*;

	// pipe-in to dispatch
	logic       in_valid;
	word_t      in_data;
	logic       in_ready;

	// dispatch to loopback
	logic       lb_valid;
	word_t      lb_data;
	logic       lb_ready;

	// dispatch to engine FIFO
	logic       eg_valid;
	word_t      eg_data;
	op_type_t   eg_op_type;
	logic       eg_last;
	logic       eg_ready;

	logic [ENG_W-1:0] eng_wr_data;
	logic [ENG_W-1:0] eng_rd_data;
	logic             eng_empty;
	logic             eng_full;

	//------------------------------
	// stages
	//------------------------------
	pipe_in_stage pin0 (
		.okClk         (okClk),
		.rst           (rst),
		.pi_write      (pi_write),
		.pi_data       (pi_data),
		.pipe_in_ready (pipe_in_ready),
		.in_valid      (in_valid),
		.in_data       (in_data),
		.in_ready      (in_ready)
	);

	op_dispatch disp0 (
		.okClk      (okClk),
		.rst        (rst),
		.op_en      (op_en),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.lb_valid   (lb_valid),
		.lb_data    (lb_data),
		.lb_ready   (lb_ready),
		.eg_valid   (eg_valid),
		.eg_data    (eg_data),
		.eg_op_type (eg_op_type),
		.eg_last    (eg_last),
		.eg_ready   (eg_ready)
	);

	pipe_out_stage pout0 (
		.okClk          (okClk),
		.rst            (rst),
		.lb_valid       (lb_valid),
		.lb_data        (lb_data),
		.lb_ready       (lb_ready),
		.po_read        (po_read),
		.po_valid       (po_valid),
		.po_data        (po_data),
		.pipe_out_ready (pipe_out_ready)
	);

	//------------------------------
	// engine side buffer
	//------------------------------
	assign eng_wr_data = {eg_last, eg_op_type, eg_data};   // {last, type, word}
	assign eg_ready = !eng_full;

	sync_fifo #(
		.WIDTH   (ENG_W)
	) eng_fifo (
		.okClk   (okClk),
		.rst     (rst),
		.wr_en   (eg_valid && eg_ready),
		.wr_data (eng_wr_data),
		.rd_en   (eng_valid && eng_ready),
		.rd_data (eng_rd_data),
		.empty   (eng_empty),
		.full    (eng_full),
		.count   ()
	);

	assign eng_valid = !eng_empty;
	assign eng_data = eng_rd_data[WORD_W-1:0];
	assign eng_op_type = op_type_t'(eng_rd_data[WORD_W+OP_TYPE_W-1:WORD_W]);
	assign eng_last = eng_rd_data[ENG_W-1];

endmodule

/* verilog/host_pkg.sv */
package host_pkg;

	//------------------------------
	// widths and sizes
	//------------------------------
	localparam int WORD_W = 32;          // host pipe word
	localparam int OP_TYPE_W = 3;
	localparam int COUNT_W = 7;          // holds 0..FIFO_DEPTH
	localparam int FIFO_DEPTH = 64;
	localparam int PTR_W = 6;            // log2 of FIFO_DEPTH
	localparam int BLOCK_SIZE = 16;      // words per host block
	localparam int BUFFER_HEADROOM = 4;  // slack for count latency

	// engine FIFO entry is {last, type, word}
	localparam int ENG_W = WORD_W + OP_TYPE_W + 1;

	//------------------------------
	// command word fields
	//------------------------------
	localparam int OP_TYPE_MSB = 31;
	localparam int OP_TYPE_LSB = 29;
	localparam int OP_NUM_MSB = 15;      // count sits in the low half

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [OP_NUM_MSB:0] op_num_t;
	typedef logic [COUNT_W-1:0] fifo_count_t;

	// codes 5..7 are reserved and get dropped by dispatch
	typedef enum logic [OP_TYPE_W-1:0] {
		OP_NONE    = 3'd0,
		OP_CONV3X3 = 3'd1,
		OP_CONV1X1 = 3'd2,
		OP_MAXPOOL = 3'd3,
		OP_AVEPOOL = 3'd4
	} op_type_t;

endpackage

/* verilog/op_dispatch.sv */
`timescale 1ns/10ps

module op_dispatch (
	input  logic               okClk,
	input  logic               rst,
	input  logic               op_en,
	input  logic               in_valid,
	input  host_pkg::word_t    in_data,
	output logic               in_ready,
	output logic               lb_valid,
	output host_pkg::word_t    lb_data,
	input  logic               lb_ready,
	output logic               eg_valid,
	output host_pkg::word_t    eg_data,
	output host_pkg::op_type_t eg_op_type,
	output logic               eg_last,
	input  logic               eg_ready
);
	import host_pkg::*;

	typedef enum logic {
		ST_CMD,
		ST_PAYLOAD
	} state_t;

	state_t   state;
	op_type_t cur_type;
	op_num_t  remain;              // payload words still to route

	op_type_t cmd_type;
	op_num_t  cmd_num;
	logic     cmd_ok;
	logic     lb_free;
	logic     eg_free;
	logic     take;
	logic     to_lb;
	logic     to_eg;
	logic     cmd_take;

	//------------------------------
	// decode and accept
	//------------------------------
	assign cmd_type = op_type_t'(in_data[OP_TYPE_MSB:OP_TYPE_LSB]);
	assign cmd_num = in_data[OP_NUM_MSB:0];
	assign cmd_ok = (in_data[OP_TYPE_MSB:OP_TYPE_LSB] <= OP_AVEPOOL) && (cmd_num != '0);

	// a slot can refill on the cycle it drains
	assign lb_free = !lb_valid || lb_ready;
	assign eg_free = !eg_valid || eg_ready;

	// command words need no slot and are always taken
	assign in_ready = !op_en ? lb_free : (state == ST_CMD) ? 1'b1 : eg_free;

	assign take = in_valid && in_ready;
	assign to_lb = take && !op_en;
	assign cmd_take = take && op_en && (state == ST_CMD);
	assign to_eg = take && op_en && (state == ST_PAYLOAD);

	//------------------------------
	// command FSM
	//------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			state <= ST_CMD;
			cur_type <= OP_NONE;
			remain <= '0;
		end else if (cmd_take) begin
			if (cmd_ok) begin                // bad commands leave us in ST_CMD
				state <= ST_PAYLOAD;
				cur_type <= cmd_type;
				remain <= cmd_num;
			end
		end else if (to_eg) begin
			remain <= remain - 1'b1;
			if (remain == op_num_t'(1)) begin
				state <= ST_CMD;             // last payload word routed
			end
		end
	end

	//------------------------------
	// output slots
	//------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			lb_valid <= 1'b0;
			eg_valid <= 1'b0;
		end else begin
			if (to_lb) begin
				lb_valid <= 1'b1;
			end else if (lb_ready) begin
				lb_valid <= 1'b0;
			end
			if (to_eg) begin
				eg_valid <= 1'b1;
			end else if (eg_ready) begin
				eg_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (to_lb) begin
			lb_data <= in_data;
		end
		if (to_eg) begin
			eg_data <= in_data;
			eg_op_type <= cur_type;          // tag with the active command
			eg_last <= (remain == op_num_t'(1));
		end
	end

endmodule

/* verilog/pipe_in_stage.sv */
`timescale 1ns/10ps

module pipe_in_stage (
	input  logic            okClk,
	input  logic            rst,
	input  logic            pi_write,
	input  host_pkg::word_t pi_data,
	output logic            pipe_in_ready,
	output logic            in_valid,
	output host_pkg::word_t in_data,
	input  logic            in_ready
);
	import host_pkg::*;

	logic        fifo_empty;
	fifo_count_t fifo_count;

	sync_fifo #(
		.WIDTH   (WORD_W)
	) in_fifo (
		.okClk   (okClk),
		.rst     (rst),
		.wr_en   (pi_write),              // host only writes after seeing pipe_in_ready
		.wr_data (pi_data),
		.rd_en   (in_valid && in_ready),
		.rd_data (in_data),
		.empty   (fifo_empty),
		.full    (),
		.count   (fifo_count)
	);

	assign in_valid = !fifo_empty;

	// block throttle, room for a whole block plus headroom
	always_ff @(posedge okClk) begin
		if (rst) begin
			pipe_in_ready <= 1'b0;
		end else begin
			pipe_in_ready <= (fifo_count <=
				fifo_count_t'(FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE));
		end
	end

endmodule

/* verilog/pipe_out_stage.sv */
`timescale 1ns/10ps

module pipe_out_stage (
	input  logic            okClk,
	input  logic            rst,
	input  logic            lb_valid,
	input  host_pkg::word_t lb_data,
	output logic            lb_ready,
	input  logic            po_read,
	output logic            po_valid,
	output host_pkg::word_t po_data,
	output logic            pipe_out_ready
);
	import host_pkg::*;

	logic        fifo_empty;
	logic        fifo_full;
	fifo_count_t fifo_count;

	sync_fifo #(
		.WIDTH   (WORD_W)
	) out_fifo (
		.okClk   (okClk),
		.rst     (rst),
		.wr_en   (lb_valid && lb_ready),
		.wr_data (lb_data),
		.rd_en   (po_read && po_valid),   // host pops the word shown
		.rd_data (po_data),
		.empty   (fifo_empty),
		.full    (fifo_full),
		.count   (fifo_count)
	);

	assign lb_ready = !fifo_full;
	assign po_valid = !fifo_empty;

	// a full block is waiting for the host
	always_ff @(posedge okClk) begin
		if (rst) begin
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_out_ready <= (fifo_count >= fifo_count_t'(BLOCK_SIZE));
		end
	end

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH = host_pkg::WORD_W
) (
	input  logic                  okClk,
	input  logic                  rst,
	input  logic                  wr_en,
	input  logic [WIDTH-1:0]      wr_data,
	input  logic                  rd_en,
	output logic [WIDTH-1:0]      rd_data,
	output logic                  empty,
	output logic                  full,
	output host_pkg::fifo_count_t count
);
	import host_pkg::*;

	logic [WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             wr_ok;
	logic             rd_ok;

	assign wr_ok = wr_en && !full;    // writes on a full buffer are dropped
	assign rd_ok = rd_en && !empty;   // so are reads on an empty one

	assign empty = (count == '0);
	assign full = (count == fifo_count_t'(FIFO_DEPTH));

	// show-ahead, head word always on the output
	assign rd_data = mem[rd_ptr];

	//------------------------------
	// storage
	//------------------------------
	always_ff @(posedge okClk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	//------------------------------
	// pointers and fill count
	//------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;     // idle or push and pop together
				end
			endcase
		end
	end

endmodule
